//--- source/enc_pkg.sv
// types shared by the 8b/10b encoder and its testbench; abcdei is sent first and kd marks a K symbol
`default_nettype none

package enc_pkg;

    // ----------------------------------------
    // field widths
    // ----------------------------------------
    localparam int BYTE_W  = 8;
    localparam int SUB5_W  = 5;
    localparam int SUB3_W  = 3;
    localparam int CODE6_W = 6;
    localparam int CODE4_W = 4;

    // ----------------------------------------
    // plain vectors
    // ----------------------------------------
    typedef logic [BYTE_W-1:0]  byte_t;   // HGFEDCBA
    typedef logic [SUB5_W-1:0]  sub5_t;   // EDCBA
    typedef logic [SUB3_W-1:0]  sub3_t;   // HGF
    typedef logic [CODE6_W-1:0] code6_t;  // abcdei, a is the msb
    typedef logic [CODE4_W-1:0] code4_t;  // fghj, f is the msb

    // running disparity
    typedef enum logic {
        RD_NEG = 1'b0,
        RD_POS = 1'b1
    } disp_t;

    // ----------------------------------------
    // bundles
    // ----------------------------------------

    // one input character
    typedef struct packed {
        logic  kd;     // 1 = control symbol
        byte_t data;
    } enc_in_t;

    // one line symbol, abcdei in bits 9..4
    typedef struct packed {
        code6_t abcdei;
        code4_t fghj;
    } symbol_t;

endpackage

`default_nettype wire

//--- source/enc_5b6b.sv
// combinational 5b/6b lookup; only K.28 has its own control code and other K codes reuse the data entry
`default_nettype none

module enc_5b6b
    import enc_pkg::*;
(
    input  sub5_t  data_low,   // EDCBA
    input  logic   kd,         // 1 = control symbol
    input  disp_t  rd_in,      // disparity before this sub-block
    output code6_t code6,      // abcdei
    output disp_t  rd_mid,     // disparity between the sub-blocks
    output logic   alt7        // x.7 must use the alternate code
);

    localparam sub5_t D7_LOW  = 5'd7;
    localparam sub5_t K28_LOW = 5'd28;

    code6_t code_neg;       // entry from the RD- column
    logic   unbalanced;     // weight other than 3 of 6
    logic   invert;

    // ----------------------------------------
    // RD- column of the 5b/6b table
    // ----------------------------------------
    always_comb begin
        case (data_low)
            5'd0:  code_neg = 6'b100111;
            5'd1:  code_neg = 6'b011101;
            5'd2:  code_neg = 6'b101101;
            5'd3:  code_neg = 6'b110001;
            5'd4:  code_neg = 6'b110101;
            5'd5:  code_neg = 6'b101001;
            5'd6:  code_neg = 6'b011001;
            5'd7:  code_neg = 6'b111000;  // balanced but has two forms
            5'd8:  code_neg = 6'b111001;
            5'd9:  code_neg = 6'b100101;
            5'd10: code_neg = 6'b010101;
            5'd11: code_neg = 6'b110100;
            5'd12: code_neg = 6'b001101;
            5'd13: code_neg = 6'b101100;
            5'd14: code_neg = 6'b011100;
            5'd15: code_neg = 6'b010111;
            5'd16: code_neg = 6'b011011;
            5'd17: code_neg = 6'b100011;
            5'd18: code_neg = 6'b010011;
            5'd19: code_neg = 6'b110010;
            5'd20: code_neg = 6'b001011;
            5'd21: code_neg = 6'b101010;
            5'd22: code_neg = 6'b011010;
            5'd23: code_neg = 6'b111010;
            5'd24: code_neg = 6'b110011;
            5'd25: code_neg = 6'b100110;
            5'd26: code_neg = 6'b010110;
            5'd27: code_neg = 6'b110110;
            5'd28: code_neg = 6'b001110;
            5'd29: code_neg = 6'b101110;
            5'd30: code_neg = 6'b011110;
            5'd31: code_neg = 6'b101011;
        endcase

        // K.28 replaces the balanced D.28 entry
        if (kd && data_low == K28_LOW) begin
            code_neg = 6'b001111;
        end
    end

    // ----------------------------------------
    // column select and disparity
    // ----------------------------------------

    // inverting a 6-bit code keeps a weight of 3 at 3
    assign unbalanced = ($countones(code_neg) != 3);

    // RD+ column is the complement for unbalanced codes and D.7
    assign invert = (rd_in == RD_POS) && (unbalanced || (!kd && data_low == D7_LOW));

    assign code6 = invert ? ~code_neg : code_neg;

    always_comb begin
        if (unbalanced) begin
            rd_mid = (rd_in == RD_NEG) ? RD_POS : RD_NEG;  // flip
        end else begin
            rd_mid = rd_in;
        end
    end

    // ----------------------------------------
    // alternate x.7 select
    // ----------------------------------------

    // avoids a run of five equal bits across the sub-block boundary
    always_comb begin
        if (rd_in == RD_NEG) begin
            alt7 = data_low inside {5'd17, 5'd18, 5'd20};
        end else begin
            alt7 = data_low inside {5'd11, 5'd13, 5'd14};
        end
    end

endmodule

`default_nettype wire

//--- source/enc_3b4b.sv
// combinational 3b/4b lookup; rd_in is the disparity after the 6b sub-block and kd selects the K table
`default_nettype none

module enc_3b4b
    import enc_pkg::*;
(
    input  sub3_t  data_high,  // HGF
    input  logic   kd,         // 1 = control symbol
    input  logic   alt7,       // from the 5b/6b stage
    input  disp_t  rd_in,      // disparity between the sub-blocks
    output code4_t code4,      // fghj
    output disp_t  rd_out      // disparity after the whole symbol
);

    localparam sub3_t X3_HIGH = 3'd3;

    code4_t data_neg;       // data entry, RD- column
    code4_t ctrl_neg;       // control entry, RD- column
    code4_t code_neg;
    logic   invert;

    // ----------------------------------------
    // RD- columns of the data and K tables
    // ----------------------------------------
    always_comb begin
        case (data_high)
            3'd0: data_neg = 4'b1011;
            3'd1: data_neg = 4'b1001;
            3'd2: data_neg = 4'b0101;
            3'd3: data_neg = 4'b1100;                     // balanced but has two forms
            3'd4: data_neg = 4'b1101;
            3'd5: data_neg = 4'b1010;
            3'd6: data_neg = 4'b0110;
            3'd7: data_neg = alt7 ? 4'b0111 : 4'b1110;    // A7 or P7
        endcase
    end

    // every control entry has its RD+ form as the complement
    always_comb begin
        case (data_high)
            3'd0: ctrl_neg = 4'b1011;
            3'd1: ctrl_neg = 4'b0110;
            3'd2: ctrl_neg = 4'b1010;
            3'd3: ctrl_neg = 4'b1100;
            3'd4: ctrl_neg = 4'b1101;
            3'd5: ctrl_neg = 4'b0101;
            3'd6: ctrl_neg = 4'b1001;
            3'd7: ctrl_neg = 4'b0111;  // always alternate
        endcase
    end

    // ----------------------------------------
    // column select and disparity
    // ----------------------------------------
    assign code_neg = kd ? ctrl_neg : data_neg;

    assign invert = (rd_in == RD_POS) &&
                    (kd || $countones(data_neg) != 2 || data_high == X3_HIGH);

    assign code4 = invert ? ~code_neg : code_neg;

    always_comb begin
        if ($countones(code4) != 2) begin
            rd_out = (rd_in == RD_NEG) ? RD_POS : RD_NEG;  // unbalanced flips
        end else begin
            rd_out = rd_in;
        end
    end

endmodule

`default_nettype wire

//--- source/enc8b10b.sv
// 8b/10b encoder with one cycle latency and no handshake; kd with a non-legal K code gives an undefined symbol
`default_nettype none

module enc8b10b
    import enc_pkg::*;
#(
    parameter disp_t RD_INIT = RD_NEG     // disparity after reset
) (
    input  logic    clk,
    input  logic    rst_n,
    input  enc_in_t enc_in,
    output symbol_t sym_out,
    output disp_t   rd_out
);

    symbol_t sym_q;
    disp_t   rd_q;      // running disparity
    disp_t   rd_mid;
    disp_t   rd_next;
    code6_t  code6;
    code4_t  code4;
    logic    alt7;

    // ----------------------------------------
    // sub-block lookups
    // ----------------------------------------
    enc_5b6b u_5b6b (
        .data_low (enc_in.data[4:0]),
        .kd       (enc_in.kd),
        .rd_in    (rd_q),
        .code6    (code6),
        .rd_mid   (rd_mid),
        .alt7     (alt7)
    );

    enc_3b4b u_3b4b (
        .data_high (enc_in.data[7:5]),
        .kd        (enc_in.kd),
        .alt7      (alt7),
        .rd_in     (rd_mid),
        .code4     (code4),
        .rd_out    (rd_next)
    );

    // ----------------------------------------
    // output and disparity registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym_q <= '0;
            rd_q  <= RD_INIT;
        end else begin
            sym_q <= '{abcdei: code6, fghj: code4};
            rd_q  <= rd_next;        // feeds the next character
        end
    end

    assign sym_out = sym_q;
    assign rd_out  = rd_q;

endmodule

`default_nettype wire

//--- test/enc8b10b_properties.sv
// checks are off while rst_n is low; kd with a byte outside the twelve legal K symbols is flagged
`default_nettype none

module enc8b10b_properties
    import enc_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input enc_in_t enc_in,
    input symbol_t sym_out,
    input disp_t   rd_out
);

    int fail_count = 0;     // failed assertions so far

    // ----------------------------------------
    // input contract
    // ----------------------------------------
    legal_k: assert property (@(posedge clk) disable iff (!rst_n)
        enc_in.kd |-> (enc_in.data inside {8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC,
                                           8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE}))
        else begin
            fail_count++;
            $error("kd set with byte %02h, not a legal K symbol", enc_in.data);
        end

    // ----------------------------------------
    // output properties
    // ----------------------------------------

    // a balanced symbol leaves the running disparity alone
    rd_flip_unbalanced: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_out != $past(rd_out)) |-> ($countones(sym_out) != 5))
        else begin
            fail_count++;
            $error("rd_out changed after balanced symbol %03h", sym_out);
        end

    // first edge after release still sees the reset symbol
    symbol_weight: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> ($countones(sym_out) inside {4, 5, 6}))
        else begin
            fail_count++;
            $error("symbol %03h has illegal weight", sym_out);
        end

endmodule

bind enc8b10b enc8b10b_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .enc_in  (enc_in),
    .sym_out (sym_out),
    .rd_out  (rd_out)
);

`default_nettype wire

//--- test/enc8b10b_tb.sv
// reads test/enc8b10b_trace.txt relative to the project root; expects RD_INIT = RD_NEG and 1 cycle latency
`default_nettype none

module enc8b10b_tb
    import enc_pkg::*;
;

    localparam disp_t RD_START       = RD_NEG;
    localparam int    TRACE_DEPTH    = 128;
    localparam int    TIMEOUT_MARGIN = 20;     // cycles on top of the trace length
    localparam string TRACE_FILE     = "test/enc8b10b_trace.txt";

    // one trace line is TT_K_DD_SSS_R in hex
    typedef logic [35:0] trace_word_t;

    logic    clk = 1'b0;
    logic    rst_n;
    enc_in_t enc_in;
    symbol_t sym_out;
    disp_t   rd_out;

    trace_word_t trace_mem [0:TRACE_DEPTH-1];
    int          n_vec        = 0;
    int          cycle_count  = 0;
    int          check_count  = 0;
    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    enc8b10b #(
        .RD_INIT (RD_START)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .enc_in  (enc_in),
        .sym_out (sym_out),
        .rd_out  (rd_out)
    );

    always #2 clk = ~clk;   // period 4

    // ----------------------------------------
    // compare tasks and reports
    // ----------------------------------------
    task automatic check_symbol(input symbol_t got, input symbol_t exp, input logic [7:0] test_no);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: test %0d symbol got %03h expected %03h",
                     $time, test_no, got, exp);
        end
    endtask

    task automatic check_disp(input disp_t got, input disp_t exp, input logic [7:0] test_no);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: test %0d rd_out got %s expected %s",
                     $time, test_no, got.name(), exp.name());
        end
    endtask

    task automatic report_test(input logic [7:0] test_no, input int vecs, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %0d: %0d vectors, ok", test_no, vecs);
        end else begin
            tests_failed++;
            $display("test %0d: %0d vectors, %0d errors", test_no, vecs, errs);
        end
    endtask

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > n_vec + TIMEOUT_MARGIN) begin
            $display("timeout: the run did not finish within %0d cycles",
                     n_vec + TIMEOUT_MARGIN);
            $display("Some tests failed");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus and checking
    // ----------------------------------------
    initial begin
        trace_word_t vec;
        logic [7:0]  cur_test;
        int          test_vecs;
        int          errs_before;

        rst_n  = 1'b0;
        enc_in = '0;
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            trace_mem[i] = '0;       // test number 0 marks the end
        end
        $readmemh(TRACE_FILE, trace_mem);
        while (n_vec < TRACE_DEPTH && trace_mem[n_vec][35:28] != 8'h00) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            error_count++;
            $display("the trace file holds no vectors");
        end

        repeat (2) @(posedge clk);
        #1;

        // test 1 checks the outputs held by reset
        errs_before = error_count;
        check_symbol(sym_out, '0, 8'd1);
        check_disp(rd_out, RD_START, 8'd1);
        report_test(8'd1, 1, error_count - errs_before);

        rst_n       = 1'b1;
        cur_test    = trace_mem[0][35:28];
        test_vecs   = 0;
        errs_before = error_count;

        for (int i = 0; i < n_vec; i++) begin
            vec = trace_mem[i];
            if (vec[35:28] != cur_test) begin
                report_test(cur_test, test_vecs, error_count - errs_before);
                cur_test    = vec[35:28];
                test_vecs   = 0;
                errs_before = error_count;
            end
            enc_in.kd   = vec[24];
            enc_in.data = vec[23:16];
            @(posedge clk);
            #1;                          // registered result of this vector
            check_symbol(sym_out, symbol_t'(vec[13:4]), cur_test);
            check_disp(rd_out, disp_t'(vec[0]), cur_test);
            test_vecs++;
        end
        if (n_vec > 0) begin
            report_test(cur_test, test_vecs, error_count - errs_before);
        end

        if (dut_i.u_props.fail_count != 0) begin
            error_count += dut_i.u_props.fail_count;
            $display("the bound checker reported %0d assertion failures",
                     dut_i.u_props.fail_count);
        end

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/enc8b10b_trace.txt
// columns are test number, kd, data HGFEDCBA, expected abcdeifghj and expected rd (0 is RD-)
// one vector per line, applied one cycle each in order and checked one cycle later
// test 2 balanced codes keep rd, D.7 and D.x.3 at both disparities
02_0_23_319_0
02_0_25_299_0
02_0_27_389_0
02_0_63_31C_0
02_0_B5_2AA_0
02_0_24_359_1
02_0_27_079_1
02_0_63_313_1
02_0_67_073_1
02_0_C5_296_1
// test 3 unbalanced codes flip rd from both sides
03_0_20_189_0
03_0_20_279_1
03_0_05_294_0
03_0_05_29B_1
03_0_BF_14A_0
03_0_BF_2BA_1
03_0_50_245_0
03_0_89_25D_1
03_0_89_252_0
03_0_18_334_0
// test 4 D.x.7 alternate code selection
04_0_F1_237_1
04_0_EB_348_0
04_0_F2_137_1
04_0_ED_2C8_0
04_0_F4_0B7_1
04_0_EE_1C8_0
04_0_EB_34E_1
04_0_F1_231_0
04_0_F7_3A1_0
04_0_E3_31E_1
// test 5 all twelve K symbols at RD+ and RD-
05_1_1C_30B_1
05_1_9C_30D_1
05_1_FC_307_1
05_1_F7_057_1
05_1_FB_097_1
05_1_FD_117_1
05_1_FE_217_1
05_1_3C_306_0
05_1_1C_0F4_0
05_1_9C_0F2_0
05_1_FC_0F8_0
05_1_F7_3A8_0
05_1_FB_368_0
05_1_FD_2E8_0
05_1_FE_1E8_0
05_1_3C_0F9_1
05_1_5C_30A_0
05_1_5C_0F5_1
05_1_7C_30C_0
05_1_7C_0F3_1
05_1_BC_305_0
05_1_BC_0FA_1
05_1_DC_309_0
05_1_DC_0F6_1
// test 6 mixed back to back stream
06_1_BC_305_0
06_0_50_1B5_1
06_0_B5_2AA_1
06_0_00_18B_1
06_0_FF_14E_1
06_1_3C_306_0
06_0_EE_1CE_1
06_0_EB_348_0
06_0_07_38B_1
06_0_07_074_0
06_1_BC_0FA_1
06_0_7E_21C_0
06_0_DD_2E6_1
06_0_98_0CD_1
06_1_FC_307_1
06_0_42_125_0

//--- vlog.f
source/enc_pkg.sv
source/enc_5b6b.sv
source/enc_3b4b.sv
source/enc8b10b.sv
test/enc8b10b_properties.sv
test/enc8b10b_tb.sv

//--- Makefile
# Verilator build and run for the 8b/10b encoder

VERILATOR  ?= verilator
TOP        ?= enc8b10b_tb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
